//--- dv/copper_checker.sv
`default_nettype none
`timescale 1ns/1ns

`include "copper_settings.svh"

module copper_checker
    import copper_xr_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       copp_reset,
    input  wire logic [`COPPER_BEAM_W-1:0]  h_count_i,
    input  wire logic [`COPPER_BEAM_W-1:0]  v_count_i,
    input  wire xr_write_t                  xr_wr_i,
    output      int                         got_o,
    output      int                         errors_o
);

    string          name;
    logic           active = 1'b0;
    int             exp_n = 0;
    int             got = 0;
    int             errors = 0;
    logic [15:0]    exp_addr [4];
    logic [15:0]    exp_data [4];
    int             exp_v [4];
    int             exp_h [4];

    assign got_o    = got;
    assign errors_o = errors;

    task automatic start_test(input string test_name, input int n);
        name   = test_name;
        exp_n  = n;
        got    = 0;
        active = 1'b1;
    endtask

    task automatic expect_write(input int idx, input logic [15:0] a, input logic [15:0] d,
                                input int v, input int h);
        exp_addr[idx] = a;
        exp_data[idx] = d;
        exp_v[idx]    = v;
        exp_h[idx]    = h;
    endtask

    // Anything still expected at the end never came
    task automatic finish_test();
        if (got < exp_n) begin
            errors++;
            $display("Test %s: %0d of %0d expected writes never happened", name, exp_n - got,
                     exp_n);
        end
        active = 1'b0;
    endtask

    // Writes and beam counts both stable at the rising edge
    always @(posedge clk) begin
        if (!copp_reset && active && xr_wr_i.en) begin
            if (got < exp_n) begin
                if (xr_wr_i.addr !== exp_addr[got] || xr_wr_i.data !== exp_data[got]) begin
                    errors++;
                    $display("Mismatch test %s write %0d: expected %h/%h actual %h/%h", name,
                             got, exp_addr[got], exp_data[got], xr_wr_i.addr, xr_wr_i.data);
                end
                // Beam position must be at or past the target
                if (int'(v_count_i) < exp_v[got] ||
                    (int'(v_count_i) == exp_v[got] && int'(h_count_i) < exp_h[got])) begin
                    errors++;
                    $display("Mismatch test %s write %0d position: expected v%0d h%0d actual v%0d h%0d",
                             name, got, exp_v[got], exp_h[got], v_count_i, h_count_i);
                end
            end else begin
                errors++;
                $display("Test %s: unexpected extra write to %h with data %h", name,
                         xr_wr_i.addr, xr_wr_i.data);
            end
            got++;
        end
    end

endmodule

`default_nettype wire

//--- dv/copper_props.sv
`default_nettype none
`timescale 1ns/1ns

module copper_props
    import copper_xr_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           copp_reset,
    input  wire logic           frame_restart,
    input  wire xr_busy_t       busy_i,
    input  wire copper_mem_rd_t mem_rd,
    input  wire xr_write_t      xr_wr
);

    xr_busy_t   busy_q;

    // Busy flag of the region a write address falls in
    function automatic logic target_busy(input logic [15:0] addr, input xr_busy_t b);
        if (addr[15:8] == 8'h00) begin
            return b.reg_busy;
        end else if (addr[15:8] == 8'h80) begin
            return b.color_busy;
        end else if (addr[15:11] == 5'b11000) begin
            return b.copper_busy;
        end
        return 1'b0;
    endfunction

    // Busy level seen in the cycle the write was issued
    always_ff @(posedge clk) begin
        busy_q <= busy_i;
    end

    // Strobe is a single-cycle pulse
    a_strobe_single: assert property (@(posedge clk) disable iff (copp_reset)
        xr_wr.en |=> !xr_wr.en)
        else $error("write strobe held for two cycles");

    // No write issued into a busy region
    a_no_busy_write: assert property (@(posedge clk) disable iff (copp_reset)
        xr_wr.en |-> !target_busy(xr_wr.addr, busy_q))
        else $error("write issued while target region busy");

    // Restart parks the FSM in INIT
    a_restart_rd_low: assert property (@(posedge clk) disable iff (copp_reset)
        frame_restart |=> !mem_rd.en)
        else $error("read strobe high after frame restart");

endmodule

bind copper_top copper_props u_props (
    .clk           (clk),
    .copp_reset    (copp_reset),
    .frame_restart (frame_restart),
    .busy_i        (busy_i),
    .mem_rd        (mem_rd_o),
    .xr_wr         (xr_wr_o)
);

`default_nettype wire

//--- dv/copper_tb.sv
`default_nettype none
`timescale 1ns/1ns

`include "copper_settings.svh"

module copper_tb
    import copper_isa_pkg::*;
    import copper_xr_pkg::*;
;

    localparam int N_TESTS = 10;
    localparam int WAIT_LIMIT = 1600;
    localparam int SETTLE = 1000;

    logic                           clk = 1'b0;
    logic                           copp_reset = 1'b1;
    logic                           ctrl_wr_i = 1'b0;
    logic [`COPPER_CTRL_NUM_W-1:0]  ctrl_num_i = '0;
    logic [`COPPER_DATA_W-1:0]      ctrl_data_i = '0;
    logic [`COPPER_BEAM_W-1:0]      h_count = '0;
    logic [`COPPER_BEAM_W-1:0]      v_count = '0;
    logic [`COPPER_DATA_W-1:0]      mem_even = '0;
    logic [`COPPER_DATA_W-1:0]      mem_odd = '0;
    xr_busy_t                       busy = '0;
    copper_mem_rd_t                 mem_rd;
    xr_write_t                      xr_wr;
    int                             chk_got;
    int                             chk_errors;

    // Copper memory image
    logic [31:0]    mem [1024];

    // Read request held over from the previous cycle
    logic                           rd_pend = 1'b0;
    logic [`COPPER_PC_W-1:0]        rd_addr = '0;

    // Stimulus table
    string          test_name [N_TESTS];
    int             init_pc [N_TESTS];
    int             start_v [N_TESTS];
    int             start_h [N_TESTS];
    logic [2:0]     busy_val [N_TESTS];
    int             busy_cyc [N_TESTS];
    int             disable_at [N_TESTS];
    logic [31:0]    prog [N_TESTS][8];
    int             n_insn [N_TESTS];
    logic [15:0]    exp_addr [N_TESTS][4];
    logic [15:0]    exp_data [N_TESTS][4];
    int             exp_v [N_TESTS][4];
    int             exp_h [N_TESTS][4];
    int             n_exp [N_TESTS];

    int             cur = -1;
    int             t;
    int             cyc;
    int             waited;
    int             tb_errors = 0;

    always #5 clk = ~clk;

    copper_top dut0 (
        .clk         (clk),
        .copp_reset  (copp_reset),
        .ctrl_wr_i   (ctrl_wr_i),
        .ctrl_num_i  (ctrl_num_i),
        .ctrl_data_i (ctrl_data_i),
        .h_count_i   (h_count),
        .v_count_i   (v_count),
        .mem_even_i  (mem_even),
        .mem_odd_i   (mem_odd),
        .busy_i      (busy),
        .mem_rd_o    (mem_rd),
        .xr_wr_o     (xr_wr)
    );

    copper_checker chk0 (
        .clk        (clk),
        .copp_reset (copp_reset),
        .h_count_i  (h_count),
        .v_count_i  (v_count),
        .xr_wr_i    (xr_wr),
        .got_o      (chk_got),
        .errors_o   (chk_errors)
    );

    // Address taken during the FETCH cycle and the word pair driven in the next cycle
    always @(negedge clk) begin
        rd_pend <= mem_rd.en;
        rd_addr <= mem_rd.addr;
        if (rd_pend) begin
            mem_even <= mem[rd_addr][31:16];
            mem_odd  <= mem[rd_addr][15:0];
        end
    end

    // Even word holds opcode, spare and addr while the odd word holds data
    function automatic logic [31:0] encode_insn(input logic [3:0] op, input logic [10:0] a,
                                                input logic [15:0] d);
        return {op, 1'b0, a, d};
    endfunction

    // Odd word of WAIT and SKIP with h in 14:4 and ignore flags in 1:0
    function automatic logic [15:0] beam_field(input logic [10:0] h, input logic ign_h,
                                               input logic ign_v);
        return {1'b0, h, 2'b00, ign_h, ign_v};
    endfunction

    task automatic new_test(input string name, input int pc0, input int sv, input int sh,
                            input logic [2:0] bv, input int bc, input int dis);
        cur++;
        test_name[cur]  = name;
        init_pc[cur]    = pc0;
        start_v[cur]    = sv;
        start_h[cur]    = sh;
        busy_val[cur]   = bv;
        busy_cyc[cur]   = bc;
        disable_at[cur] = dis;
        n_insn[cur]     = 0;
        n_exp[cur]      = 0;
    endtask

    task automatic add_insn(input logic [31:0] w);
        prog[cur][n_insn[cur]] = w;
        n_insn[cur]++;
    endtask

    task automatic add_write(input logic [15:0] a, input logic [15:0] d, input int v,
                             input int h);
        exp_addr[cur][n_exp[cur]] = a;
        exp_data[cur][n_exp[cur]] = d;
        exp_v[cur][n_exp[cur]]    = v;
        exp_h[cur][n_exp[cur]]    = h;
        n_exp[cur]++;
    endtask

    task automatic build_table();
        new_test("moves", 0, 10, 0, 3'b000, 0, 0);
        add_insn(encode_insn(OP_MOVER, 11'h012, 16'hA5A5));
        add_insn(encode_insn(OP_MOVEP, 11'h034, 16'h1234));
        add_insn(encode_insn(OP_MOVEC, 11'h5AB, 16'hBEEF));
        add_insn(encode_insn(OP_JMP, 11'd6, 16'h0000));
        add_write(16'h0012, 16'hA5A5, 0, 0);
        add_write(16'h8034, 16'h1234, 0, 0);
        add_write(16'hC5AB, 16'hBEEF, 0, 0);
        // Former MOVEF and an unused opcode both act as NOPs
        new_test("illegal", 0, 10, 0, 3'b000, 0, 0);
        add_insn(encode_insn(4'b1010, 11'h012, 16'h5555));
        add_insn(encode_insn(4'b1111, 11'h000, 16'h0000));
        add_insn(encode_insn(OP_MOVER, 11'h001, 16'h0077));
        add_insn(encode_insn(OP_JMP, 11'd6, 16'h0000));
        add_write(16'h0001, 16'h0077, 0, 0);
        new_test("jump", 0, 10, 0, 3'b000, 0, 0);
        add_insn(encode_insn(OP_JMP, 11'd4, 16'h0000));
        add_insn(encode_insn(OP_MOVER, 11'h002, 16'hDEAD));
        add_insn(encode_insn(OP_MOVER, 11'h003, 16'h0003));
        add_insn(encode_insn(OP_JMP, 11'd6, 16'h0000));
        add_write(16'h0003, 16'h0003, 0, 0);
        new_test("skip_passed", 0, 10, 0, 3'b000, 0, 0);
        add_insn(encode_insn(OP_SKIP, 11'd5, beam_field(11'd0, 1'b0, 1'b0)));
        add_insn(encode_insn(OP_MOVER, 11'h004, 16'h4444));
        add_insn(encode_insn(OP_MOVER, 11'h005, 16'h5555));
        add_insn(encode_insn(OP_JMP, 11'd6, 16'h0000));
        add_write(16'h0005, 16'h5555, 0, 0);
        new_test("skip_ahead", 0, 10, 0, 3'b000, 0, 0);
        add_insn(encode_insn(OP_SKIP, 11'd200, beam_field(11'd0, 1'b0, 1'b0)));
        add_insn(encode_insn(OP_MOVER, 11'h004, 16'h4444));
        add_insn(encode_insn(OP_MOVER, 11'h005, 16'h5555));
        add_insn(encode_insn(OP_JMP, 11'd6, 16'h0000));
        add_write(16'h0004, 16'h4444, 0, 0);
        add_write(16'h0005, 16'h5555, 0, 0);
        new_test("skip_ignored", 0, 10, 0, 3'b000, 0, 0);
        add_insn(encode_insn(OP_SKIP, 11'd500, beam_field(11'd700, 1'b1, 1'b1)));
        add_insn(encode_insn(OP_MOVER, 11'h004, 16'h4444));
        add_insn(encode_insn(OP_MOVER, 11'h005, 16'h5555));
        add_insn(encode_insn(OP_JMP, 11'd6, 16'h0000));
        add_write(16'h0005, 16'h5555, 0, 0);
        // Second WAIT ignores h, so line 13 alone releases it
        new_test("wait_pos", 0, 11, 600, 3'b000, 0, 0);
        add_insn(encode_insn(OP_WAIT, 11'd12, beam_field(11'd300, 1'b0, 1'b0)));
        add_insn(encode_insn(OP_MOVER, 11'h006, 16'h6666));
        add_insn(encode_insn(OP_WAIT, 11'd13, beam_field(11'd700, 1'b1, 1'b0)));
        add_insn(encode_insn(OP_MOVER, 11'h007, 16'h7777));
        add_insn(encode_insn(OP_JMP, 11'd8, 16'h0000));
        add_write(16'h0006, 16'h6666, 12, 300);
        add_write(16'h0007, 16'h7777, 13, 0);
        // Restart reruns the program from pc 16 in the new frame
        new_test("restart", 16, 523, 400, 3'b000, 0, 0);
        add_insn(encode_insn(OP_MOVER, 11'h008, 16'h8888));
        add_insn(encode_insn(OP_JMP, 11'd34, 16'h0000));
        add_write(16'h0008, 16'h8888, 523, 400);
        add_write(16'h0008, 16'h8888, 0, 0);
        new_test("busy", 0, 10, 0, 3'b010, 100, 0);
        add_insn(encode_insn(OP_MOVEP, 11'h005, 16'hC0DE));
        add_insn(encode_insn(OP_JMP, 11'd2, 16'h0000));
        add_write(16'h8005, 16'hC0DE, 10, 100);
        // Enable cleared while the WAIT is pending
        new_test("disable", 0, 10, 0, 3'b000, 0, 200);
        add_insn(encode_insn(OP_MOVER, 11'h009, 16'h0909));
        add_insn(encode_insn(OP_WAIT, 11'd11, beam_field(11'd0, 1'b0, 1'b0)));
        add_insn(encode_insn(OP_MOVER, 11'h00A, 16'h0A0A));
        add_insn(encode_insn(OP_JMP, 11'd6, 16'h0000));
        add_write(16'h0009, 16'h0909, 0, 0);
    endtask

    // NOP fill tagged with its own address, then the program on top
    task automatic load_program(input int idx);
        logic [9:0] a;
        for (int i = 0; i < 1024; i++) begin
            a = 10'(i);
            mem[i] = {4'hF, 2'b00, a, 6'h00, a};
        end
        for (int k = 0; k < n_insn[idx]; k++) begin
            mem[init_pc[idx] + k] = prog[idx][k];
        end
    endtask

    // One pixel per clock with inputs changed on the falling edge
    task automatic step_cycle();
        @(negedge clk);
        cyc++;
        ctrl_wr_i = 1'b0;
        if (cyc == disable_at[t]) begin
            ctrl_wr_i   = 1'b1;
            ctrl_data_i = 16'h0000;
        end
        if (cyc == busy_cyc[t]) begin
            busy = '0;
        end
        if (h_count == 11'(`COPPER_H_TOTAL - 1)) begin
            h_count = '0;
            v_count = (v_count == 11'(`COPPER_V_TOTAL - 1)) ? '0 : v_count + 1'b1;
        end else begin
            h_count = h_count + 1'b1;
        end
    endtask

    initial begin
        repeat (N_TESTS * 2000) @(posedge clk);
        $display("Watchdog expired after %0d cycles with tests still running", N_TESTS * 2000);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        build_table();
        repeat (16) @(posedge clk);
        for (t = 0; t < N_TESTS; t++) begin
            load_program(t);
            chk0.start_test(test_name[t], n_exp[t]);
            for (int k = 0; k < n_exp[t]; k++) begin
                chk0.expect_write(k, exp_addr[t][k], exp_data[t][k], exp_v[t][k],
                                  exp_h[t][k]);
            end
            // Leave reset with the control write and beam start together
            @(negedge clk);
            copp_reset  = 1'b0;
            h_count     = 11'(start_h[t]);
            v_count     = 11'(start_v[t]);
            busy        = xr_busy_t'(busy_val[t]);
            ctrl_wr_i   = 1'b1;
            ctrl_num_i  = 4'(`COPPER_CTRL_REG_NUM);
            ctrl_data_i = {1'b1, 5'b00000, 10'(init_pc[t])};
            cyc    = 0;
            waited = 0;
            while (chk_got < n_exp[t] && waited < WAIT_LIMIT) begin
                step_cycle();
                waited++;
            end
            if (chk_got < n_exp[t]) begin
                tb_errors++;
                $display("Test %s timed out waiting for its writes", test_name[t]);
            end
            // Quiet period catches late or extra writes
            repeat (SETTLE) step_cycle();
            chk0.finish_test();
            @(negedge clk);
            copp_reset = 1'b1;
            ctrl_wr_i  = 1'b0;
            busy       = '0;
            repeat (4) @(negedge clk);
        end
        $display("Done: %0d checker errors, %0d testbench errors", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --timing -f src.f --top-module copper_tb -o Vcopper_tb

./obj_dir/Vcopper_tb > sim.log
cat sim.log

if grep -q "^Test OK$" sim.log; then
    exit 0
else
    exit 1
fi

//--- src.f
+incdir+src
src/copper_isa_pkg.sv
src/copper_xr_pkg.sv
src/copper_sequencer.sv
src/copper_program_counter.sv
src/copper_beam_compare.sv
src/copper_xr_writer.sv
src/copper_top.sv
dv/copper_props.sv
dv/copper_checker.sv
dv/copper_tb.sv

//--- src/copper_beam_compare.sv
`default_nettype none
`timescale 1ns/1ns

`include "copper_settings.svh"

module copper_beam_compare
    import copper_isa_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       copp_reset,
    input  wire logic [`COPPER_BEAM_W-1:0]  h_count_i,
    input  wire logic [`COPPER_BEAM_W-1:0]  v_count_i,
    input  wire logic                       precomp_i,
    input  wire copper_insn_t               insn_i,
    output      logic                       frame_restart_o,
    output      logic                       cond_met_o
);

    localparam logic [`COPPER_BEAM_W-1:0] RESTART_H =
        `COPPER_BEAM_W'(`COPPER_H_TOTAL - `COPPER_RESTART_H_OFFSET);
    localparam logic [`COPPER_BEAM_W-1:0] RESTART_V =
        `COPPER_BEAM_W'(`COPPER_V_TOTAL - 1);

    logic                       v_reached;
    logic                       h_reached;
    logic [`COPPER_BEAM_W-1:0]  h_pos;
    logic                       cond_met_q;

    // Last line, a few pixels early so the first fetch is done by pixel 0
    assign frame_restart_o = (h_count_i == RESTART_H) && (v_count_i == RESTART_V);

    // Horizontal target sits in the odd word
    assign h_pos = insn_i.data[14:4];

    // Ignore flags force their axis true
    assign v_reached = insn_i.data[0] || (v_count_i >= insn_i.addr);
    assign h_reached = insn_i.data[1] || (h_count_i >= h_pos);

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            cond_met_q <= 1'b0;
        end else if (precomp_i) begin
            cond_met_q <= v_reached && h_reached;
        end
    end

    assign cond_met_o = cond_met_q;

endmodule

`default_nettype wire

//--- src/copper_isa_pkg.sv
`default_nettype none

`include "copper_settings.svh"

package copper_isa_pkg;

    // Instruction opcodes in the top nibble of the even word
    // Anything not listed here runs as a four cycle NOP
    typedef enum logic [3:0] {
        OP_WAIT  = 4'b0000,
        OP_SKIP  = 4'b0010,
        OP_JMP   = 4'b0100,
        OP_MOVER = 4'b1001,
        OP_MOVEP = 4'b1011,
        OP_MOVEC = 4'b1100
    } copper_opcode_t;

    // Per-instruction execution steps
    typedef enum logic [2:0] {
        ST_INIT    = 3'd0,
        ST_FETCH   = 3'd1,
        ST_LATCH   = 3'd2,
        ST_PRECOMP = 3'd3,
        ST_EXEC    = 3'd4
    } copper_state_t;

    // Even word in the upper half, odd word in the lower half
    // data[14:4] is the horizontal position for WAIT and SKIP
    // data[1] ignores horizontal, data[0] ignores vertical
    typedef struct packed {
        copper_opcode_t                 opcode;
        logic                           spare;
        logic [`COPPER_BEAM_W-1:0]      addr;
        logic [`COPPER_DATA_W-1:0]      data;
    } copper_insn_t;

endpackage

`default_nettype wire

//--- src/copper_program_counter.sv
`default_nettype none
`timescale 1ns/1ns

`include "copper_settings.svh"

module copper_program_counter
    import copper_isa_pkg::*;
(
    input  wire logic                           clk,
    input  wire logic                           copp_reset,
    input  wire logic                           ctrl_wr_i,
    input  wire logic [`COPPER_CTRL_NUM_W-1:0]  ctrl_num_i,
    input  wire logic [`COPPER_DATA_W-1:0]      ctrl_data_i,
    input  wire logic                           frame_restart_i,
    input  wire logic                           pc_inc_i,
    input  wire logic                           pc_skip_i,
    input  wire logic                           pc_jump_i,
    input  wire copper_insn_t                   insn_i,
    output      logic                           copper_en_o,
    output      logic [`COPPER_PC_W-1:0]        mem_rd_addr_o
);

    localparam logic [`COPPER_CTRL_NUM_W-1:0] CTRL_REG = `COPPER_CTRL_REG_NUM;

    logic                       ctrl_sel;
    logic                       copper_en_q;
    logic [`COPPER_PC_W-1:0]    init_pc_q;
    logic [`COPPER_PC_W-1:0]    pc_q;

    assign ctrl_sel = ctrl_wr_i && (ctrl_num_i == CTRL_REG);

    // Control register, bit 15 enable and bits 9:0 initial pc
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            copper_en_q <= 1'b0;
            init_pc_q   <= '0;
        end else if (ctrl_sel) begin
            copper_en_q <= ctrl_data_i[15];
            init_pc_q   <= ctrl_data_i[`COPPER_PC_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            pc_q <= '0;
        end else if (frame_restart_i) begin
            pc_q <= init_pc_q;
        end else if (ctrl_sel) begin
            // New program starts at its initial pc without waiting a frame
            pc_q <= ctrl_data_i[`COPPER_PC_W-1:0];
        end else if (pc_jump_i) begin
            // Jump target is a word address, drop bit 0
            pc_q <= insn_i.addr[`COPPER_PC_W:1];
        end else if (pc_skip_i || pc_inc_i) begin
            // pc already points past the SKIP, one more steps over the next
            pc_q <= pc_q + 1'b1;
        end
    end

    assign copper_en_o   = copper_en_q;
    assign mem_rd_addr_o = pc_q;

endmodule

`default_nettype wire

//--- src/copper_sequencer.sv
`default_nettype none
`timescale 1ns/1ns

`include "copper_settings.svh"

module copper_sequencer
    import copper_isa_pkg::*;
    import copper_xr_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       copp_reset,
    input  wire logic                       frame_restart_i,
    input  wire logic                       copper_en_i,
    input  wire logic                       cond_met_i,
    input  wire xr_busy_t                   busy_i,
    input  wire logic [`COPPER_DATA_W-1:0]  mem_even_i,
    input  wire logic [`COPPER_DATA_W-1:0]  mem_odd_i,
    output      copper_insn_t               insn_o,
    output      logic                       mem_rd_en_o,
    output      logic                       pc_inc_o,
    output      logic                       pc_skip_o,
    output      logic                       pc_jump_o,
    output      logic                       precomp_o,
    output      logic                       move_go_o
);

    copper_state_t  state_q;
    copper_state_t  state_d;
    copper_insn_t   insn_q;
    logic           is_move;
    logic           region_busy;
    logic           in_exec;

    // Pick the busy flag of the region the MOVE targets
    always_comb begin
        is_move     = 1'b0;
        region_busy = 1'b0;
        case (insn_q.opcode)
            OP_MOVER: begin
                is_move     = 1'b1;
                region_busy = busy_i.reg_busy;
            end
            OP_MOVEP: begin
                is_move     = 1'b1;
                region_busy = busy_i.color_busy;
            end
            OP_MOVEC: begin
                is_move     = 1'b1;
                region_busy = busy_i.copper_busy;
            end
            default: ;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_INIT: begin
                if (copper_en_i) begin
                    state_d = ST_FETCH;
                end
            end
            // Disabling mid-program parks the FSM here
            ST_FETCH:   state_d = copper_en_i ? ST_LATCH : ST_INIT;
            ST_LATCH:   state_d = ST_PRECOMP;
            ST_PRECOMP: state_d = ST_EXEC;
            ST_EXEC: begin
                if (insn_q.opcode == OP_WAIT) begin
                    // Failed WAIT goes back to sample the beam again
                    state_d = cond_met_i ? ST_FETCH : ST_PRECOMP;
                end else if (is_move && region_busy) begin
                    state_d = ST_EXEC;
                end else begin
                    state_d = ST_FETCH;
                end
            end
            default:    state_d = ST_INIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            state_q <= ST_INIT;
        end else if (frame_restart_i) begin
            state_q <= ST_INIT;
        end else begin
            state_q <= state_d;
        end
    end

    // Memory data for the FETCH address is valid in LATCH
    always_ff @(posedge clk) begin
        if (state_q == ST_LATCH) begin
            insn_q <= copper_insn_t'({mem_even_i, mem_odd_i});
        end
    end

    assign in_exec     = (state_q == ST_EXEC);
    assign insn_o      = insn_q;
    assign mem_rd_en_o = (state_q == ST_FETCH);
    assign pc_inc_o    = (state_q == ST_FETCH) && copper_en_i;
    assign precomp_o   = (state_q == ST_PRECOMP);
    assign pc_skip_o   = in_exec && (insn_q.opcode == OP_SKIP) && cond_met_i;
    assign pc_jump_o   = in_exec && (insn_q.opcode == OP_JMP);
    assign move_go_o   = in_exec && is_move && !region_busy;

endmodule

`default_nettype wire

//--- src/copper_settings.svh
`ifndef COPPER_SETTINGS_SVH
`define COPPER_SETTINGS_SVH

// Copper program counter, one step per 32-bit instruction
`define COPPER_PC_W 10

// XR bus address and data widths
`define COPPER_XR_ADDR_W 16
`define COPPER_DATA_W 16

// Beam counters and position fields
`define COPPER_BEAM_W 11

// Video timing totals for 640x480
`define COPPER_H_TOTAL 800
`define COPPER_V_TOTAL 525

// Restart this many pixels before the end of the last line
`define COPPER_RESTART_H_OFFSET 5

// XR region bases for MOVEP and MOVEC
`define COPPER_XR_COLOR_BASE 16'h8000
`define COPPER_XR_COPPER_BASE 16'hC000

// Control register select
`define COPPER_CTRL_NUM_W 4
`define COPPER_CTRL_REG_NUM 1

`endif

//--- src/copper_top.sv
`default_nettype none
`timescale 1ns/1ns

`include "copper_settings.svh"

module copper_top
    import copper_isa_pkg::*;
    import copper_xr_pkg::*;
(
    input  wire logic                           clk,
    input  wire logic                           copp_reset,
    input  wire logic                           ctrl_wr_i,
    input  wire logic [`COPPER_CTRL_NUM_W-1:0]  ctrl_num_i,
    input  wire logic [`COPPER_DATA_W-1:0]      ctrl_data_i,
    input  wire logic [`COPPER_BEAM_W-1:0]      h_count_i,
    input  wire logic [`COPPER_BEAM_W-1:0]      v_count_i,
    input  wire logic [`COPPER_DATA_W-1:0]      mem_even_i,
    input  wire logic [`COPPER_DATA_W-1:0]      mem_odd_i,
    input  wire xr_busy_t                       busy_i,
    output      copper_mem_rd_t                 mem_rd_o,
    output      xr_write_t                      xr_wr_o
);

    logic                       copper_en;
    logic [`COPPER_PC_W-1:0]    pc;
    logic                       mem_rd_en;
    logic                       pc_inc;
    logic                       pc_skip;
    logic                       pc_jump;
    logic                       precomp;
    logic                       move_go;
    logic                       frame_restart;
    logic                       cond_met;
    copper_insn_t               insn;

    // Read port, address straight from the pc
    assign mem_rd_o = '{en: mem_rd_en, addr: pc};

    copper_sequencer u_sequencer (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .frame_restart_i (frame_restart),
        .copper_en_i     (copper_en),
        .cond_met_i      (cond_met),
        .busy_i          (busy_i),
        .mem_even_i      (mem_even_i),
        .mem_odd_i       (mem_odd_i),
        .insn_o          (insn),
        .mem_rd_en_o     (mem_rd_en),
        .pc_inc_o        (pc_inc),
        .pc_skip_o       (pc_skip),
        .pc_jump_o       (pc_jump),
        .precomp_o       (precomp),
        .move_go_o       (move_go)
    );

    copper_program_counter u_pc (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .ctrl_wr_i       (ctrl_wr_i),
        .ctrl_num_i      (ctrl_num_i),
        .ctrl_data_i     (ctrl_data_i),
        .frame_restart_i (frame_restart),
        .pc_inc_i        (pc_inc),
        .pc_skip_i       (pc_skip),
        .pc_jump_i       (pc_jump),
        .insn_i          (insn),
        .copper_en_o     (copper_en),
        .mem_rd_addr_o   (pc)
    );

    copper_beam_compare u_beam (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .h_count_i       (h_count_i),
        .v_count_i       (v_count_i),
        .precomp_i       (precomp),
        .insn_i          (insn),
        .frame_restart_o (frame_restart),
        .cond_met_o      (cond_met)
    );

    copper_xr_writer u_writer (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .frame_restart_i (frame_restart),
        .move_go_i       (move_go),
        .insn_i          (insn),
        .xr_wr_o         (xr_wr_o)
    );

endmodule

`default_nettype wire

//--- src/copper_xr_pkg.sv
`default_nettype none

`include "copper_settings.svh"

package copper_xr_pkg;

    // One XR bus write, en is a single-cycle strobe
    typedef struct packed {
        logic                           en;
        logic [`COPPER_XR_ADDR_W-1:0]   addr;
        logic [`COPPER_DATA_W-1:0]      data;
    } xr_write_t;

    // Busy levels of the writable regions
    typedef struct packed {
        logic   reg_busy;
        logic   color_busy;
        logic   copper_busy;
    } xr_busy_t;

    // Copper memory read port, data returns one cycle later
    typedef struct packed {
        logic                           en;
        logic [`COPPER_PC_W-1:0]        addr;
    } copper_mem_rd_t;

endpackage

`default_nettype wire

//--- src/copper_xr_writer.sv
`default_nettype none
`timescale 1ns/1ns

`include "copper_settings.svh"

module copper_xr_writer
    import copper_isa_pkg::*;
    import copper_xr_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           copp_reset,
    input  wire logic           frame_restart_i,
    input  wire logic           move_go_i,
    input  wire copper_insn_t   insn_i,
    output      xr_write_t      xr_wr_o
);

    localparam logic [`COPPER_XR_ADDR_W-1:0] COLOR_BASE  = `COPPER_XR_COLOR_BASE;
    localparam logic [`COPPER_XR_ADDR_W-1:0] COPPER_BASE = `COPPER_XR_COPPER_BASE;

    logic [`COPPER_XR_ADDR_W-1:0]   addr_d;
    logic                           wr_en_q;
    logic [`COPPER_XR_ADDR_W-1:0]   wr_addr_q;
    logic [`COPPER_DATA_W-1:0]      wr_data_q;

    // Target address by MOVE flavour
    always_comb begin
        case (insn_i.opcode)
            // XR register number in the low byte
            OP_MOVER: addr_d = {8'h00, insn_i.addr[7:0]};
            // Colour index in the low byte
            OP_MOVEP: addr_d = {COLOR_BASE[15:8], insn_i.addr[7:0]};
            // Full 11-bit copper word address
            OP_MOVEC: addr_d = COPPER_BASE | `COPPER_XR_ADDR_W'(insn_i.addr);
            default:  addr_d = '0;
        endcase
    end

    // Strobe is high only the cycle after move_go
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            wr_en_q <= 1'b0;
        end else if (frame_restart_i) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= move_go_i;
        end
    end

    always_ff @(posedge clk) begin
        if (move_go_i) begin
            wr_addr_q <= addr_d;
            wr_data_q <= insn_i.data;
        end
    end

    assign xr_wr_o = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

endmodule

`default_nettype wire
